// File: mem_pipe_consts.svh
// memory slice constants for data width, RAM window and timer register offsets
`ifndef MEM_PIPE_CONSTS_SVH
`define MEM_PIPE_CONSTS_SVH

// ##################################################
// datapath
// ##################################################
`define MP_XLEN         32

// ##################################################
// data RAM window, 1 KiB of 32-bit words
// ##################################################
`define MP_RAM_BASE     32'h8000_0000
`define MP_RAM_WORDS    256

// ##################################################
// timer register block
// ##################################################
`define MP_CLINT_BASE   32'h0200_0000
`define MP_MTIMECMP_LO  16'h4000
`define MP_MTIMECMP_HI  16'h4004
`define MP_MTIME_LO     16'hBFF8
`define MP_MTIME_HI     16'hBFFC

`endif

// File: mem_pipe_pkg.sv
// shared types for the memory-access slice: load/store codes, exceptions, stage structs
`include "mem_pipe_consts.svh"

package mem_pipe_pkg;

    // load/store operation carried from execute
    typedef enum logic [3:0] {
        LS_NONE = 4'd0,
        LS_LB   = 4'd1,
        LS_LH   = 4'd2,
        LS_LW   = 4'd3,
        LS_LBU  = 4'd4,
        LS_LHU  = 4'd5,
        LS_SB   = 4'd6,
        LS_SH   = 4'd7,
        LS_SW   = 4'd8
    } ls_op_e;

    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_MISALIGN = 2'd1,
        EXC_ACCESS   = 2'd2
    } exc_e;

    // execute result entering the memory stage
    typedef struct packed {
        logic               valid;
        logic [`MP_XLEN-1:0] pc;
        logic [`MP_XLEN-1:0] inst;
        logic [7:0]         inst_type;
        logic               rd_ena;
        logic [4:0]         rd_addr;
        logic [`MP_XLEN-1:0] rd_data;
        ls_op_e             ls_op;
        logic [`MP_XLEN-1:0] ls_addr;
        logic               fence_ready;
    } ex_mem_t;

    typedef struct packed {
        logic               valid;
        logic [`MP_XLEN-1:0] pc;
        logic [`MP_XLEN-1:0] inst;
        logic               rd_ena;
        logic [4:0]         rd_addr;
        logic [`MP_XLEN-1:0] rd_data;
        exc_e               exc;
        logic               fence_ready;
    } wb_t;

endpackage

// File: ex_mem_reg.sv
// execute-to-memory pipeline register that holds on stall and clears on reset
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  mem_pipe_pkg::ex_mem_t ex_i,
    output mem_pipe_pkg::ex_mem_t mem_o
);

    import mem_pipe_pkg::*;

    // ##################################################
    // stage register
    // ##################################################
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_o.valid       <= 1'b0;
            mem_o.pc          <= '0;
            mem_o.inst        <= '0;
            mem_o.inst_type   <= '0;
            mem_o.rd_ena      <= 1'b0;
            mem_o.rd_addr     <= '0;
            mem_o.rd_data     <= '0;
            mem_o.ls_op       <= LS_NONE;
            mem_o.ls_addr     <= '0;
            mem_o.fence_ready <= 1'b0;
        end else if (!stall_i) begin
            mem_o <= ex_i;
        end
        // a stalled edge keeps the previous contents
    end

endmodule

// File: lsu.sv
// load/store unit: address decode, alignment check, store lane steering, load extension
`timescale 1ns/1ps
`include "mem_pipe_consts.svh"

module lsu (
    input  mem_pipe_pkg::ex_mem_t             mem_i,
    input  logic                              stall_i,
    output logic                              ram_we_o,
    output logic [3:0]                        ram_be_o,
    output logic [$clog2(`MP_RAM_WORDS)-1:0]  ram_addr_o,
    output logic [`MP_XLEN-1:0]               ram_wdata_o,
    input  logic [`MP_XLEN-1:0]               ram_rdata_i,
    output logic                              clint_we_o,
    output logic                              clint_re_o,
    output logic [15:0]                       clint_offset_o,
    output logic [`MP_XLEN-1:0]               clint_wdata_o,
    input  logic [`MP_XLEN-1:0]               clint_rdata_i,
    output mem_pipe_pkg::wb_t                 res_o
);

    import mem_pipe_pkg::*;

    localparam int          RAM_AW     = $clog2(`MP_RAM_WORDS);
    localparam logic [31:0] RAM_BASE   = `MP_RAM_BASE;
    localparam logic [31:0] CLINT_BASE = `MP_CLINT_BASE;

    logic                is_load;
    logic                is_store;
    logic                sign_ext;
    logic [1:0]          size;
    logic                misaligned;
    logic                in_ram;
    logic                in_clint;
    logic                req_ok;
    exc_e                exc;
    logic [`MP_XLEN-1:0] rdata_word;
    logic [7:0]          load_byte;
    logic [15:0]         load_half;
    logic [`MP_XLEN-1:0] load_val;

    // ##################################################
    // decode
    // ##################################################
    assign is_load  = mem_i.ls_op inside {LS_LB, LS_LH, LS_LW, LS_LBU, LS_LHU};
    assign is_store = mem_i.ls_op inside {LS_SB, LS_SH, LS_SW};
    assign sign_ext = mem_i.ls_op inside {LS_LB, LS_LH};

    // size 0 is a byte, 1 a halfword, 2 a word
    always_comb begin
        case (mem_i.ls_op)
            LS_LB, LS_LBU, LS_SB: size = 2'd0;
            LS_LH, LS_LHU, LS_SH: size = 2'd1;
            default:              size = 2'd2;
        endcase
    end

    assign misaligned = (size == 2'd1 && mem_i.ls_addr[0]) ||
                        (size == 2'd2 && mem_i.ls_addr[1:0] != 2'b00);
    assign in_ram     = mem_i.ls_addr[31:RAM_AW+2] == RAM_BASE[31:RAM_AW+2];
    assign in_clint   = mem_i.ls_addr[31:16] == CLINT_BASE[31:16] &&
                        mem_i.ls_addr[15:0] inside {`MP_MTIMECMP_LO, `MP_MTIMECMP_HI,
                                                    `MP_MTIME_LO, `MP_MTIME_HI};

    always_comb begin
        if (!(is_load || is_store)) begin
            exc = EXC_NONE;
        end else if (misaligned) begin
            exc = EXC_MISALIGN;
        end else if (in_ram || (in_clint && size == 2'd2)) begin
            exc = EXC_NONE;
        end else begin
            // timer registers only take full words
            exc = EXC_ACCESS;
        end
    end

    assign req_ok = mem_i.valid && exc == EXC_NONE;

    // ##################################################
    // store path
    // ##################################################
    assign ram_we_o       = req_ok && is_store && in_ram && !stall_i;
    assign clint_we_o     = req_ok && is_store && in_clint && !stall_i;
    assign clint_re_o     = req_ok && is_load && in_clint;
    assign ram_addr_o     = mem_i.ls_addr[RAM_AW+1:2];
    assign clint_offset_o = mem_i.ls_addr[15:0];
    assign clint_wdata_o  = mem_i.rd_data;

    always_comb begin
        case (size)
            2'd0: begin
                ram_be_o    = 4'b0001 << mem_i.ls_addr[1:0];
                ram_wdata_o = {4{mem_i.rd_data[7:0]}};
            end
            2'd1: begin
                ram_be_o    = 4'b0011 << mem_i.ls_addr[1:0];
                ram_wdata_o = {2{mem_i.rd_data[15:0]}};
            end
            default: begin
                ram_be_o    = 4'b1111;
                ram_wdata_o = mem_i.rd_data;
            end
        endcase
    end

    // ##################################################
    // load path
    // ##################################################
    assign rdata_word = in_ram ? ram_rdata_i : clint_rdata_i;
    assign load_byte  = rdata_word[8*mem_i.ls_addr[1:0] +: 8];
    assign load_half  = mem_i.ls_addr[1] ? rdata_word[31:16] : rdata_word[15:0];

    always_comb begin
        case (size)
            2'd0:    load_val = {{24{sign_ext & load_byte[7]}}, load_byte};
            2'd1:    load_val = {{16{sign_ext & load_half[15]}}, load_half};
            default: load_val = rdata_word;
        endcase
    end

    always_comb begin
        res_o.valid       = mem_i.valid;
        res_o.pc          = mem_i.pc;
        res_o.inst        = mem_i.inst;
        res_o.rd_addr     = mem_i.rd_addr;
        res_o.fence_ready = mem_i.fence_ready;
        res_o.exc         = exc;
        res_o.rd_ena      = mem_i.rd_ena && !is_store && exc == EXC_NONE;
        res_o.rd_data     = (is_load && exc == EXC_NONE) ? load_val : mem_i.rd_data;
    end

endmodule

// File: data_ram.sv
// byte-writable data memory with synchronous write and combinational read
`timescale 1ns/1ps
`include "mem_pipe_consts.svh"

module data_ram #(
    parameter int WORDS = 256
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [3:0]               be_i,
    input  logic [$clog2(WORDS)-1:0] addr_i,
    input  logic [`MP_XLEN-1:0]      wdata_i,
    output logic [`MP_XLEN-1:0]      rdata_o
);

    logic [`MP_XLEN-1:0] mem [WORDS];

    // only the enabled byte lanes change
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[addr_i];

endmodule

// File: clint_regs.sv
// timer register block with mtime, mtimecmp and a registered interrupt level
`timescale 1ns/1ps
`include "mem_pipe_consts.svh"

module clint_regs (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                stall_i,
    input  logic                we_i,
    input  logic                re_i,
    input  logic [15:0]         offset_i,
    input  logic [`MP_XLEN-1:0] wdata_i,
    output logic [`MP_XLEN-1:0] rdata_o,
    output logic                timer_irq_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtime_d;
    logic [63:0] mtimecmp_q;

    // a write to either mtime half replaces the increment for that edge
    always_comb begin
        mtime_d = mtime_q + 64'd1;
        if (we_i && offset_i == `MP_MTIME_LO) begin
            mtime_d = {mtime_q[63:32], wdata_i};
        end else if (we_i && offset_i == `MP_MTIME_HI) begin
            mtime_d = {wdata_i, mtime_q[31:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            timer_irq_o <= 1'b0;
        end else begin
            if (!stall_i) begin
                mtime_q <= mtime_d;
            end
            if (we_i && offset_i == `MP_MTIMECMP_LO) begin
                mtimecmp_q[31:0] <= wdata_i;
            end
            if (we_i && offset_i == `MP_MTIMECMP_HI) begin
                mtimecmp_q[63:32] <= wdata_i;
            end
            timer_irq_o <= mtime_q >= mtimecmp_q;
        end
    end

    always_comb begin
        rdata_o = '0;
        if (re_i) begin
            case (offset_i)
                `MP_MTIMECMP_LO: rdata_o = mtimecmp_q[31:0];
                `MP_MTIMECMP_HI: rdata_o = mtimecmp_q[63:32];
                `MP_MTIME_LO:    rdata_o = mtime_q[31:0];
                `MP_MTIME_HI:    rdata_o = mtime_q[63:32];
                default:         rdata_o = '0;
            endcase
        end
    end

endmodule

// File: mem_wb_reg.sv
// memory-to-writeback pipeline register that holds on stall and clears on reset
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  mem_pipe_pkg::wb_t res_i,
    output mem_pipe_pkg::wb_t wb_o
);

    import mem_pipe_pkg::*;

    // ##################################################
    // stage register
    // ##################################################
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_o.valid       <= 1'b0;
            wb_o.pc          <= '0;
            wb_o.inst        <= '0;
            wb_o.rd_ena      <= 1'b0;
            wb_o.rd_addr     <= '0;
            wb_o.rd_data     <= '0;
            wb_o.exc         <= EXC_NONE;
            wb_o.fence_ready <= 1'b0;
        end else if (!stall_i) begin
            wb_o <= res_i;
        end
        // the writeback result stays put while stalled
    end

endmodule

// File: mem_pipe_top.sv
// memory-access slice top level joining the stage registers, LSU, data RAM and timer block
`timescale 1ns/1ps
`include "mem_pipe_consts.svh"

module mem_pipe_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  mem_pipe_pkg::ex_mem_t ex_i,
    output mem_pipe_pkg::wb_t     wb_o,
    output logic                  timer_irq_o
);

    import mem_pipe_pkg::*;

    localparam int RAM_AW = $clog2(`MP_RAM_WORDS);

    ex_mem_t             mem_q;
    wb_t                 mem_res;

    logic                ram_we;
    logic [3:0]          ram_be;
    logic [RAM_AW-1:0]   ram_word_addr;
    logic [`MP_XLEN-1:0] ram_wdata;
    logic [`MP_XLEN-1:0] ram_rdata;

    logic                clint_we;
    logic                clint_re;
    logic [15:0]         clint_offset;
    logic [`MP_XLEN-1:0] clint_wdata;
    logic [`MP_XLEN-1:0] clint_rdata;

    ex_mem_reg u_ex_mem_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stall_i (stall_i),
        .ex_i    (ex_i),
        .mem_o   (mem_q)
    );

    lsu u_lsu (
        .mem_i          (mem_q),
        .stall_i        (stall_i),
        .ram_we_o       (ram_we),
        .ram_be_o       (ram_be),
        .ram_addr_o     (ram_word_addr),
        .ram_wdata_o    (ram_wdata),
        .ram_rdata_i    (ram_rdata),
        .clint_we_o     (clint_we),
        .clint_re_o     (clint_re),
        .clint_offset_o (clint_offset),
        .clint_wdata_o  (clint_wdata),
        .clint_rdata_i  (clint_rdata),
        .res_o          (mem_res)
    );

    data_ram #(
        .WORDS (`MP_RAM_WORDS)
    ) u_data_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .be_i    (ram_be),
        .addr_i  (ram_word_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    clint_regs u_clint_regs (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .we_i        (clint_we),
        .re_i        (clint_re),
        .offset_i    (clint_offset),
        .wdata_i     (clint_wdata),
        .rdata_o     (clint_rdata),
        .timer_irq_o (timer_irq_o)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stall_i (stall_i),
        .res_i   (mem_res),
        .wb_o    (wb_o)
    );

endmodule

// File: mem_pipe_props.sv
// concurrent checks on the writeback output and RAM write enable of the memory slice
`timescale 1ns/1ps

module mem_pipe_props (
    input logic              clk,
    input logic              rst_n_i,
    input logic              stall_i,
    input logic              ram_we_i,
    input mem_pipe_pkg::wb_t wb_i
);

    import mem_pipe_pkg::*;

    // ##################################################
    // writeback stage
    // ##################################################
    wb_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> $stable(wb_i))
        else $error("writeback result changed across a stalled edge");

    // covers the first edge after release as well
    reset_clear_a: assert property (@(posedge clk)
        !rst_n_i |=> !wb_i.valid)
        else $error("writeback valid high during or right after reset");

    fault_no_write_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_i.exc != EXC_NONE |-> !wb_i.rd_ena)
        else $error("faulting result still enables the register write");

    // ##################################################
    // memory side
    // ##################################################
    ram_we_stall_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(ram_we_i && stall_i))
        else $error("RAM write enable high while stalled");

endmodule

bind mem_pipe_top mem_pipe_props u_props (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .stall_i  (stall_i),
    .ram_we_i (ram_we),
    .wb_i     (wb_o)
);

// File: tb_mem_pipe.sv
// testbench for the memory-access slice, driven and checked from the golden file
`timescale 1ns/1ps
`include "mem_pipe_consts.svh"

module tb_mem_pipe;

    import mem_pipe_pkg::*;

    localparam int WAIT_LIMIT = 50;

    // one golden line, the stimulus and what writeback must show for it
    typedef struct packed {
        ex_mem_t     ex;
        logic [31:0] exp_data;
        logic        exp_ena;
        logic [1:0]  exp_exc;
        logic [1:0]  exp_irq;
    } golden_t;

    logic    clk;
    logic    rst_n_i;
    logic    stall_i;
    ex_mem_t ex_i;
    wb_t     wb_o;
    logic    timer_irq_o;

    golden_t stim_q[$];
    golden_t exp_q[$];
    int      checked;

    mem_pipe_top DUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .ex_i        (ex_i),
        .wb_o        (wb_o),
        .timer_irq_o (timer_irq_o)
    );

    always #20 clk = ~clk;

    // ##################################################
    // reporting
    // ##################################################
    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            stop_on_failure("writeback value mismatch");
        end
    endtask

    // ##################################################
    // golden file
    // ##################################################
    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] op, pc, inst, rd, ena, data, addr, fence;
        logic [31:0] e_data, e_ena, e_exc, e_irq;
        golden_t     g;
        fd = $fopen("mem_pipe_golden.txt", "r");
        if (fd == 0) begin
            stop_on_failure("could not open mem_pipe_golden.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", op, pc, inst, rd,
                            ena, data, addr, fence, e_data, e_ena, e_exc, e_irq);
                if (n != 12) begin
                    stop_on_failure("malformed line in the golden file");
                end
                g.ex.valid       = 1'b1;
                g.ex.pc          = pc;
                g.ex.inst        = inst;
                g.ex.inst_type   = '0;
                g.ex.rd_ena      = ena[0];
                g.ex.rd_addr     = rd[4:0];
                g.ex.rd_data     = data;
                g.ex.ls_op       = ls_op_e'(op[3:0]);
                g.ex.ls_addr     = addr;
                g.ex.fence_ready = fence[0];
                g.exp_data       = e_data;
                g.exp_ena        = e_ena[0];
                g.exp_exc        = e_exc[1:0];
                g.exp_irq        = e_irq[1:0];
                stim_q.push_back(g);
                exp_q.push_back(g);
            end
        end
        $fclose(fd);
    endtask

    // ##################################################
    // stimulus and checking
    // ##################################################
    task automatic drive_ops();
        int n_stall;
        foreach (stim_q[i]) begin
            ex_i    = stim_q[i].ex;
            n_stall = 0;
            // upstream keeps the op on ex_i while stalled
            while (n_stall < 4 && $urandom % 5 == 0) begin
                stall_i = 1'b1;
                n_stall++;
                @(posedge clk);
                #1;
            end
            stall_i = 1'b0;
            @(posedge clk);
            #1;
        end
        ex_i = '0;
    endtask

    // a result counts once, at the unstalled edge that moves it out of writeback
    task automatic check_results();
        golden_t g;
        int      waited;
        while (exp_q.size() > 0) begin
            waited = 0;
            @(negedge clk);
            while ((stall_i || !wb_o.valid) && waited < WAIT_LIMIT) begin
                waited++;
                @(negedge clk);
            end
            if (waited >= WAIT_LIMIT) begin
                stop_on_failure("timeout: no writeback result arrived within 50 cycles");
            end else begin
                g = exp_q.pop_front();
                check_value("pc", wb_o.pc, g.ex.pc);
                check_value("inst", wb_o.inst, g.ex.inst);
                check_value("rd_addr", 32'(wb_o.rd_addr), 32'(g.ex.rd_addr));
                check_value("rd_data", wb_o.rd_data, g.exp_data);
                check_value("rd_ena", 32'(wb_o.rd_ena), 32'(g.exp_ena));
                check_value("exc", 32'(wb_o.exc), 32'(g.exp_exc));
                check_value("fence_ready", 32'(wb_o.fence_ready), 32'(g.ex.fence_ready));
                if (g.exp_irq != 2'd2) begin
                    check_value("timer_irq_o", 32'(timer_irq_o), 32'(g.exp_irq));
                end
                checked++;
            end
        end
    endtask

    initial begin
        clk     = 1'b0;
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        ex_i    = '0;
        checked = 0;
        void'($urandom(93));
        load_golden();
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        fork
            drive_ops();
            check_results();
        join
        // nothing valid may follow the last expected result
        for (int idle = 0; idle < 4; idle++) begin
            @(negedge clk);
            if (wb_o.valid) begin
                stop_on_failure("an extra writeback result appeared after the last one");
            end
        end
        if (checked == stim_q.size() && checked > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_on_failure("not every golden operation was checked");
        end
    end

endmodule

// File: mem_pipe_top.f
+incdir+.
mem_pipe_pkg.sv
ex_mem_reg.sv
lsu.sv
data_ram.sv
clint_regs.sv
mem_wb_reg.sv
mem_pipe_top.sv
mem_pipe_props.sv
tb_mem_pipe.sv

// File: Makefile
# Verilator build for the memory-access slice
VERILATOR ?= verilator
TOP       ?= tb_mem_pipe
FILELIST  ?= mem_pipe_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) mem_pipe_consts.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: mem_pipe_golden.txt
# op pc inst rd_addr rd_ena rd_data ls_addr fence  exp_rd_data exp_rd_ena exp_exc exp_irq
# hex; op 0 none 1 lb 2 lh 3 lw 4 lbu 5 lhu 6 sb 7 sh 8 sw; exc 0 none 1 misalign 2 access; irq 2 = unchecked
0 00000100 00a00093 01 1 0000000a 00000000 0  0000000a 1 0 0
0 00000104 0000100f 00 0 12345678 00000000 1  12345678 0 0 0
0 00000108 deadcfb7 1f 1 deadbeef 00000000 0  deadbeef 1 0 0
8 0000010c 0020a823 00 0 11223344 80000010 0  11223344 0 0 0
3 00000110 0100a283 05 1 00000000 80000010 0  11223344 1 0 0
7 00000114 00209923 00 0 0000a5b6 80000012 0  0000a5b6 0 0 0
6 00000118 002088a3 00 0 000000f0 80000011 0  000000f0 0 0 0
3 0000011c 0100a303 06 1 00000000 80000010 0  a5b6f044 1 0 0
2 00000120 01209383 07 1 00000000 80000012 0  ffffa5b6 1 0 0
5 00000124 0120d403 08 1 00000000 80000012 0  0000a5b6 1 0 0
1 00000128 01108483 09 1 00000000 80000011 0  fffffff0 1 0 0
4 0000012c 0110c503 0a 1 00000000 80000011 0  000000f0 1 0 0
1 00000130 01008583 0b 1 00000000 80000010 0  00000044 1 0 0
2 00000134 01009603 0c 1 00000000 80000010 0  fffff044 1 0 0
8 00000138 0020a923 00 0 99999999 80000012 0  99999999 0 1 0
3 0000013c 0110a683 0d 1 00000000 80000011 0  00000000 0 1 0
2 00000140 01309703 0e 1 00000000 80000013 0  00000000 0 1 0
7 00000144 00211023 00 0 00007777 90000000 0  00007777 0 2 0
3 00000148 0000a783 0f 1 00000000 00001000 0  00000000 0 2 0
3 0000014c 4000a803 10 1 00000000 80000400 0  00000000 0 2 0
3 00000150 0100a883 11 1 00000000 80000010 0  a5b6f044 1 0 0
8 00000154 00012023 00 0 00000000 02004000 0  00000000 0 0 0
3 00000158 00012903 12 1 00000000 02004000 0  00000000 1 0 0
3 0000015c 00412983 13 1 00000000 02004004 0  ffffffff 1 0 0
8 00000160 00012223 00 0 00000000 02004004 0  00000000 0 0 2
3 00000164 00412a03 14 1 00000000 02004004 0  00000000 1 0 1
0 00000168 00100a93 15 1 00000001 00000000 0  00000001 1 0 1
8 0000016c 01f12223 00 0 ffffffff 02004004 0  ffffffff 0 0 2
3 00000170 00412b03 16 1 00000000 02004004 0  ffffffff 1 0 0
8 00000174 01f12023 00 0 ffffffff 02004000 0  ffffffff 0 0 0
7 00000178 00011023 00 0 00001234 02004000 0  00001234 0 2 0
1 0000017c 00010b83 17 1 00000000 02004000 0  00000000 0 2 0
3 00000180 00012c03 18 1 00000000 02004000 0  ffffffff 1 0 0
0 00000184 cafefcb7 19 1 cafef00d 00000000 1  cafef00d 1 0 0
